// ==== Makefile ====
TOP = cpu_bus_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f cpu_bus.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== cpu_bus.f ====
source/bus_pkg.sv
source/axi_pkg.sv
source/sraml_arbiter.sv
source/sraml_to_axi.sv
source/axi_sram.sv
source/cpu_bus_top.sv
dv/cpu_bus_tb.sv

// ==== dv/cpu_bus_tb.sv ====
module cpu_bus_tb
    import bus_pkg::*;
();

    localparam int mem_words    = 1024;
    // addresses stay in the first 64 bytes, bits 11:6 clear
    localparam int region_words = 16;
    localparam int n_fill       = region_words;
    localparam int n_mixed      = 80;
    localparam int n_check      = region_words;
    localparam int n_txn        = n_fill + 2 * n_mixed + n_check;
    // a transaction takes at most 8 cycles, plus reset and slack
    localparam int max_cycles   = 10 * n_txn + 80;

    logic       clk;
    logic       rst_n;
    sraml_req_t mreq [2];
    sraml_rsp_t mrsp [2];

    integer     seed;
    int         cycle_count = 0;

    // byte-wide reference memory for the region
    logic [7:0] ref_mem [region_words * 4];

    // request accepted by addr_ok and still waiting for data_ok
    sraml_req_t pend [2];
    logic       pend_valid [2];
    logic       req_seen [2];
    // addr_ok pulses one port won while the other kept req high
    int         wins [2];

    cpu_bus_top #(
        .mem_words (mem_words)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst_req (mreq[0]),
        .inst_rsp (mrsp[0]),
        .data_req (mreq[1]),
        .data_rsp (mrsp[1])
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic string port_name(input int p);
        return (p == 0) ? "inst" : "data";
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // little endian lanes, wdata right aligned
    function automatic void model_write(input sraml_req_t t);
        logic [5:0] a;
        a = t.addr[5:0];
        case (t.size)
            size_byte: begin
                ref_mem[a] = t.wdata[7:0];
            end
            size_half: begin
                ref_mem[{a[5:1], 1'b0}] = t.wdata[7:0];
                ref_mem[{a[5:1], 1'b1}] = t.wdata[15:8];
            end
            default: begin
                for (int b = 0; b < 4; b++) begin
                    ref_mem[{a[5:2], 2'(b)}] = t.wdata[8*b +: 8];
                end
            end
        endcase
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        logic [5:0] a;
        a = {addr[5:2], 2'b00};
        return {ref_mem[a + 6'd3], ref_mem[a + 6'd2], ref_mem[a + 6'd1], ref_mem[a]};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // present one request and hold it until addr_ok
    task automatic issue(input int p, input logic wr, input logic [1:0] size,
                         input logic [31:0] addr, input logic [31:0] wdata);
        mreq[p].req   = 1'b1;
        mreq[p].wr    = wr;
        mreq[p].size  = size;
        mreq[p].addr  = addr;
        mreq[p].wdata = wdata;
        while (!mrsp[p].addr_ok) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic drain(input int p);
        mreq[p].req = 1'b0;
        while (pend_valid[p]) begin
            next_cycle();
        end
    endtask

    task automatic fill_memory();
        logic [31:0] addr;
        for (int i = 0; i < region_words; i++) begin
            addr = 32'(i * 4);
            issue(1, 1'b1, size_word, addr, $random(seed) ^ addr);
        end
        drain(1);
    endtask

    task automatic fetch_stream(input int n);
        logic [31:0] pc;
        for (int i = 0; i < n; i++) begin
            // sequential fetch, upper bits alias onto the same words
            pc = (32'(i) << 12) | 32'((i * 4) % (region_words * 4));
            issue(0, 1'b0, size_word, pc, 32'h0);
        end
        drain(0);
    endtask

    task automatic data_stream(input int n);
        logic [31:0] r;
        logic [31:0] wd;
        logic [31:0] addr;
        for (int i = 0; i < n; i++) begin
            r    = $random(seed);
            wd   = $random(seed);
            addr = {r[31:12], 6'b000000, r[9:4]};
            case (r[1:0])
                2'd0:    issue(1, 1'b1, size_word, {addr[31:2], 2'b00}, wd);
                2'd1:    issue(1, 1'b1, size_half, {addr[31:1], 1'b0}, wd);
                2'd2:    issue(1, 1'b1, size_byte, addr, wd);
                default: issue(1, 1'b0, size_word, {addr[31:2], 2'b00}, 32'h0);
            endcase
        end
        drain(1);
    endtask

    task automatic read_back_all();
        for (int i = 0; i < region_words; i++) begin
            issue(0, 1'b0, size_word, 32'(i * 4), 32'h0);
        end
        drain(0);
    endtask

    initial begin
        seed    = 32'h5e18_4979;
        rst_n   = 1'b0;
        mreq[0] = '0;
        mreq[1] = '0;
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        // quiet cycles, no port may answer yet
        repeat (4) next_cycle();
        fill_memory();
        fork
            fetch_stream(n_mixed);
            data_stream(n_mixed);
        join
        read_back_all();
        $display("Done: no errors");
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            stop_with_error($sformatf("timeout after %0d cycles, the tests did not finish",
                                      cycle_count));
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < 2; p++) begin
                pend_valid[p] <= 1'b0;
                req_seen[p]   <= 1'b0;
                wins[p]       <= 0;
            end
        end else begin
            for (int p = 0; p < 2; p++) begin
                int q;
                q = 1 - p;
                if (mreq[p].req) begin
                    req_seen[p] <= 1'b1;
                end
                if (mrsp[p].addr_ok) begin
                    assert (!pend_valid[p]) else stop_with_error($sformatf(
                        "%s port got addr_ok before data_ok of its last request",
                        port_name(p)));
                    pend[p]       <= mreq[p];
                    pend_valid[p] <= 1'b1;
                end
                if (mrsp[p].data_ok) begin
                    assert (pend_valid[p]) else stop_with_error($sformatf(
                        "%s port got data_ok with no accepted request", port_name(p)));
                    pend_valid[p] <= 1'b0;
                    if (pend[p].wr) begin
                        model_write(pend[p]);
                    end else begin
                        assert (mrsp[p].rdata === model_word(pend[p].addr))
                        else stop_with_error($sformatf(
                            "FAILED time %0t %s_rsp.rdata got %08h expected %08h",
                            $time, port_name(p), mrsp[p].rdata,
                            model_word(pend[p].addr)));
                    end
                end
                // round robin, one win per turn while the other waits
                if (!mreq[q].req || mrsp[q].addr_ok) begin
                    wins[p] <= 0;
                end else if (mrsp[p].addr_ok) begin
                    assert (wins[p] == 0) else stop_with_error($sformatf(
                        "%s port was accepted twice while %s port kept waiting",
                        port_name(p), port_name(q)));
                    wins[p] <= wins[p] + 1;
                end
            end
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_port
        a_quiet_before_req: assert property (
            @(posedge clk) disable iff (!rst_n)
            !req_seen[p] |-> !mrsp[p].addr_ok && !mrsp[p].data_ok
        ) else stop_with_error($sformatf("%s port answered before its first request",
                                         port_name(p)));

        a_data_ok_pulse: assert property (
            @(posedge clk) disable iff (!rst_n)
            mrsp[p].data_ok |=> !mrsp[p].data_ok
        ) else stop_with_error($sformatf("%s port held data_ok for two cycles",
                                         port_name(p)));
    end

endmodule

// ==== source/axi_pkg.sv ====
package axi_pkg;

    // single beat bursts only
    localparam logic [3:0] axi_len_single = 4'd0;

    // one data word seen whole or per byte lane
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] bytes;
    } axi_word_u;

    // read address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  len;
        logic [2:0]  size;
    } axi_ar_t;

    // write address channel
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  len;
        logic [2:0]  size;
    } axi_aw_t;

    // write data channel
    typedef struct packed {
        axi_word_u  data;
        logic [3:0] strb;
        logic       last;
    } axi_w_t;

    // read data channel
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } axi_r_t;

endpackage

// ==== source/axi_sram.sv ====
module axi_sram
    import axi_pkg::*;
#(
    parameter int mem_words = 1024
) (
    input  logic    clk,
    input  logic    rst_n,
    // read address
    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,
    // read data
    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready,
    // write address
    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,
    // write data
    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,
    // write response
    output logic    bvalid,
    input  logic    bready
);

    // depth is a power of two, upper address bits wrap
    localparam int idx_w = $clog2(mem_words);

    logic [31:0]      mem [mem_words];
    logic             wr_pend;
    logic [idx_w-1:0] waddr;
    logic [idx_w-1:0] raddr;
    logic [31:0]      rdata_q;
    logic             idle;
    axi_word_u        old_word;
    axi_word_u        new_word;

    assign raddr = ar.addr[idx_w+1:2];

    assign idle    = !rvalid && !wr_pend && !bvalid;
    assign arready = idle;
    assign awready = idle;
    assign wready  = wr_pend;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid  <= 1'b0;
            wr_pend <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end

            if (awvalid && awready) begin
                wr_pend <= 1'b1;
            end else if (wvalid && wready) begin
                wr_pend <= 1'b0;
            end

            if (wvalid && wready) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            rdata_q <= mem[raddr];
        end
        if (awvalid && awready) begin
            waddr <= aw.addr[idx_w+1:2];
        end
    end

    assign r.data = rdata_q;
    assign r.last = 1'b1;

    // read-modify-write under strb, lane by lane
    always_comb begin
        old_word.word = mem[waddr];
        new_word      = old_word;
        for (int b = 0; b < 4; b++) begin
            if (w.strb[b]) begin
                new_word.bytes[b] = w.data.bytes[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wvalid && wready) begin
            mem[waddr] <= new_word.word;
        end
    end

    a_rvalid_after_ar: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(rvalid) |-> $past(arvalid && arready)
    );

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

    // sram-like size encoding, bytes = 1 << size
    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    // peer masters sharing the bus
    // index 0 is instruction fetch, index 1 is data
    localparam int n_masters = 2;

    typedef logic [$clog2(n_masters)-1:0] master_idx_t;

    // request bundle, held stable from req until addr_ok
    typedef struct packed {
        logic        req;
        logic        wr;
        logic [1:0]  size;
        logic [31:0] addr;
        // right-aligned write data, the bridge moves it into byte lanes
        logic [31:0] wdata;
    } sraml_req_t;

    // response bundle
    typedef struct packed {
        // request accepted this cycle
        logic        addr_ok;
        // one cycle pulse, rdata valid alongside
        logic        data_ok;
        // full aligned word, the master picks its bytes
        logic [31:0] rdata;
    } sraml_rsp_t;

endpackage

// ==== source/cpu_bus_top.sv ====
module cpu_bus_top
    import bus_pkg::*, axi_pkg::*;
#(
    parameter int mem_words = 1024
) (
    input  logic       clk,
    input  logic       rst_n,
    input  sraml_req_t inst_req,
    output sraml_rsp_t inst_rsp,
    input  sraml_req_t data_req,
    output sraml_rsp_t data_rsp
);

    sraml_req_t [n_masters-1:0] mst_req;
    sraml_rsp_t [n_masters-1:0] mst_rsp;
    sraml_req_t                 br_req;
    sraml_rsp_t                 br_rsp;

    axi_ar_t ar;
    axi_r_t  r;
    axi_aw_t aw;
    axi_w_t  w;
    logic    arvalid;
    logic    arready;
    logic    rvalid;
    logic    rready;
    logic    awvalid;
    logic    awready;
    logic    wvalid;
    logic    wready;
    logic    bvalid;
    logic    bready;

    // fetch on port 0, data on port 1
    assign mst_req[0] = inst_req;
    assign mst_req[1] = data_req;
    assign inst_rsp   = mst_rsp[0];
    assign data_rsp   = mst_rsp[1];

    sraml_arbiter arb_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mst_req (mst_req),
        .mst_rsp (mst_rsp),
        .slv_req (br_req),
        .slv_rsp (br_rsp)
    );

    sraml_to_axi bridge_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sraml_req (br_req),
        .sraml_rsp (br_rsp),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .aw        (aw),
        .awvalid   (awvalid),
        .awready   (awready),
        .w         (w),
        .wvalid    (wvalid),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    axi_sram #(
        .mem_words (mem_words)
    ) ram_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// ==== source/sraml_arbiter.sv ====
module sraml_arbiter
    import bus_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  sraml_req_t [n_masters-1:0]  mst_req,
    output sraml_rsp_t [n_masters-1:0]  mst_rsp,
    output sraml_req_t                  slv_req,
    input  sraml_rsp_t                  slv_rsp
);

    logic        busy;
    // doubles as the last-granted pointer once busy drops
    master_idx_t grant;
    master_idx_t pick;
    logic        found;

    // round robin, first requester after the last grant
    always_comb begin
        master_idx_t cand;
        pick  = grant;
        found = 1'b0;
        for (int k = 1; k <= n_masters; k++) begin
            cand = master_idx_t'((int'(grant) + k) % n_masters);
            if (!found && mst_req[cand].req) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            // so that master 0 wins the first pick
            grant <= master_idx_t'(n_masters - 1);
        end else if (!busy) begin
            if (found) begin
                busy  <= 1'b1;
                grant <= pick;
            end
        end else if (slv_rsp.data_ok) begin
            busy <= 1'b0;
        end
    end

    // only the granted master reaches the bridge
    always_comb begin
        slv_req     = mst_req[grant];
        slv_req.req = busy && mst_req[grant].req;
    end

    // handshakes back to the owner, the rest keep waiting
    always_comb begin
        for (int i = 0; i < n_masters; i++) begin
            mst_rsp[i].rdata   = slv_rsp.rdata;
            mst_rsp[i].addr_ok = busy && (grant == master_idx_t'(i)) && slv_rsp.addr_ok;
            mst_rsp[i].data_ok = busy && (grant == master_idx_t'(i)) && slv_rsp.data_ok;
        end
    end

    // grant stays put until the bridge finishes the transaction
    a_grant_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        busy && !slv_rsp.data_ok |=> busy && $stable(grant)
    );

endmodule

// ==== source/sraml_to_axi.sv ====
module sraml_to_axi
    import bus_pkg::*, axi_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  sraml_req_t sraml_req,
    output sraml_rsp_t sraml_rsp,
    // read address
    output axi_ar_t    ar,
    output logic       arvalid,
    input  logic       arready,
    // read data
    input  axi_r_t     r,
    input  logic       rvalid,
    output logic       rready,
    // write address
    output axi_aw_t    aw,
    output logic       awvalid,
    input  logic       awready,
    // write data
    output axi_w_t     w,
    output logic       wvalid,
    input  logic       wready,
    // write response
    input  logic       bvalid,
    output logic       bready
);

    logic       do_req;
    logic       addr_rcv;
    logic       wdata_rcv;
    logic       data_back;
    logic       start;
    sraml_req_t cur;

    assign start     = sraml_req.req && !do_req;
    assign data_back = addr_rcv && ((rvalid && rready) || (bvalid && bready));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            do_req    <= 1'b0;
            addr_rcv  <= 1'b0;
            wdata_rcv <= 1'b0;
        end else begin
            if (start) begin
                do_req <= 1'b1;
            end else if (data_back) begin
                do_req <= 1'b0;
            end

            if ((arvalid && arready) || (awvalid && awready)) begin
                addr_rcv <= 1'b1;
            end else if (data_back) begin
                addr_rcv <= 1'b0;
            end

            if (wvalid && wready) begin
                wdata_rcv <= 1'b1;
            end else if (data_back) begin
                wdata_rcv <= 1'b0;
            end
        end
    end

    // master may move on after addr_ok, keep our own copy
    always_ff @(posedge clk) begin
        if (start) begin
            cur <= sraml_req;
        end
    end

    assign sraml_rsp.addr_ok = (arvalid && arready) || (awvalid && awready);
    assign sraml_rsp.data_ok = data_back;
    assign sraml_rsp.rdata   = r.data;

    assign ar.addr = cur.addr;
    assign ar.len  = axi_len_single;
    assign ar.size = {1'b0, cur.size};
    assign arvalid = !cur.wr && do_req && !addr_rcv;

    assign rready = addr_rcv;

    assign aw.addr = cur.addr;
    assign aw.len  = axi_len_single;
    assign aw.size = {1'b0, cur.size};
    assign awvalid = cur.wr && do_req && !addr_rcv;

    // strobe from size and low address bits, data moved to its lanes
    always_comb begin
        w.data.word = cur.wdata;
        w.last      = 1'b1;
        case (cur.size)
            size_byte: begin
                w.strb                      = 4'b0001 << cur.addr[1:0];
                w.data.bytes[cur.addr[1:0]] = cur.wdata[7:0];
            end
            size_half: begin
                w.strb                            = 4'b0011 << {cur.addr[1], 1'b0};
                w.data.bytes[{cur.addr[1], 1'b0}] = cur.wdata[7:0];
                w.data.bytes[{cur.addr[1], 1'b1}] = cur.wdata[15:8];
            end
            size_word: begin
                w.strb = 4'b1111;
            end
            default: begin
                w.strb = 4'b1111;
            end
        endcase
    end

    assign wvalid = cur.wr && addr_rcv && !wdata_rcv;

    assign bready = 1'b1;

    a_one_addr_channel: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(arvalid && awvalid)
    );

endmodule
